/* project.f */
+incdir+include
source/fifo_pkg.sv
source/gray_sync.sv
source/fifo_mem.sv
source/fifo_wr_ctrl.sv
source/fifo_rd_ctrl.sv
source/async_fifo.sv
test/tb_async_fifo.sv

/* Makefile */
TOP := tb_async_fifo
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Iinclude -f project.f --top-module $(TOP)

# The simulation status is ignored here, the log search decides.
run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -Iinclude -f project.f --top-module async_fifo

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_async_fifo.sv */
`include "fifo_defines.svh"

module tb_async_fifo;

  import fifo_pkg::*;

  localparam int WR_HALF         = 4;
  localparam int RD_PERIOD       = 13;
  localparam int RESET_CYCLES    = 8;
  localparam int PHASE_CYCLES    = 300;
  localparam int RD_PHASE_CYCLES = PHASE_CYCLES * 8 / RD_PERIOD;
  // Random phases plus fills, drains and settle waits of all tests.
  localparam int TOTAL_CYCLES  = RESET_CYCLES + 3 * PHASE_CYCLES + 40 * (`FIFO_DEPTH + 20);
  localparam int WATCHDOG_TIME = TOTAL_CYCLES * RD_PERIOD * 2;

  logic  wr_clk;
  logic  rd_clk;
  logic  rd_rst_n;
  logic  wr_en;
  data_t wr_data;
  logic  rd_en;
  data_t rd_data;
  logic  full;
  logic  afull;
  logic  empty;
  logic  aempty;

  data_t model [$];
  logic  rd_pending;
  data_t expected_word;
  data_t last_read;
  int    errors;
  int    checks;
  int    writes;
  int    reads;
  int    test_errors;
  int    test_checks;
  string test_name;

  logic  wr_pat [PHASE_CYCLES];
  data_t data_pat [PHASE_CYCLES];
  logic  rd_pat [PHASE_CYCLES];

  async_fifo uut (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #WR_HALF wr_clk = ~wr_clk;
  end

  // Uneven halves give a 13 unit period.
  initial begin
    rd_clk = 1'b0;
    forever begin
      #6 rd_clk = 1'b1;
      #7 rd_clk = 1'b0;
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the run was still going after %0d time units", WATCHDOG_TIME);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("MISMATCH at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // The accept decision is made here, since full only moves on the rising edge.
  task automatic write_step(input logic en, input data_t d);
    @(negedge wr_clk);
    wr_en   = en;
    wr_data = d;
    if (en && !full) begin
      assert (model.size() < `FIFO_DEPTH) else begin
        errors++;
        $display("Write accepted at time %0t while the model already held %0d words",
                 $time, model.size());
      end
      model.push_back(d);
      writes++;
    end
  endtask

  // Checks the word of the previous accepted read, then drives the next strobe.
  task automatic read_step(input logic en);
    @(negedge rd_clk);
    if (rd_pending) begin
      check_word("rd_data", rd_data, expected_word);
      last_read  = expected_word;
      rd_pending = 1'b0;
    end
    rd_en = en;
    if (en && !empty) begin
      assert (model.size() > 0) else begin
        errors++;
        $display("Read accepted at time %0t while the model was empty", $time);
      end
      if (model.size() > 0) begin
        expected_word = model.pop_front();
        rd_pending    = 1'b1;
        reads++;
      end
    end
  endtask

  task automatic run_random_phase(input int wr_pct, input int rd_pct);
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      wr_pat[i]   = ($urandom % 100) < wr_pct;
      data_pat[i] = data_t'($urandom);
      rd_pat[i]   = ($urandom % 100) < rd_pct;
    end
    fork
      begin
        for (int i = 0; i < PHASE_CYCLES; i++) begin
          write_step(wr_pat[i], data_pat[i]);
        end
        write_step(1'b0, '0);
      end
      begin
        for (int j = 0; j < RD_PHASE_CYCLES; j++) begin
          read_step(rd_pat[j]);
        end
        read_step(1'b0);
      end
    join
  endtask

  task automatic fill_to(input int level);
    while (model.size() < level) begin
      write_step(1'b1, data_t'($urandom));
    end
    write_step(1'b0, '0);
  endtask

  task automatic drain_all();
    while (model.size() > 0 || rd_pending) begin
      read_step(1'b1);
    end
    read_step(1'b0);
  endtask

  task automatic settle_and_check_flags();
    int count;
    write_step(1'b0, '0);
    repeat (10) read_step(1'b0);
    count = model.size();
    check_bit("full", full, count == `FIFO_DEPTH);
    check_bit("afull", afull, count >= `FIFO_AFULL);
    check_bit("empty", empty, count == 0);
    check_bit("aempty", aempty, count <= `FIFO_AEMPTY);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
    test_checks = checks;
  endtask

  task automatic end_test();
    $display("Test %-28s %0d checks, %0d errors", test_name,
             checks - test_checks, errors - test_errors);
  endtask

  initial begin
    int base;
    rd_rst_n      = 1'b0;
    wr_en         = 1'b0;
    wr_data       = '0;
    rd_en         = 1'b0;
    rd_pending    = 1'b0;
    expected_word = '0;
    last_read     = '0;
    errors        = 0;
    checks        = 0;
    writes        = 0;
    reads         = 0;
    void'($urandom(32'hdba8));
    repeat (RESET_CYCLES) @(negedge wr_clk);
    rd_rst_n = 1'b1;

    start_test("reset state");
    repeat (4) read_step(1'b0);
    check_bit("empty", empty, 1'b1);
    check_bit("aempty", aempty, 1'b1);
    check_bit("full", full, 1'b0);
    check_bit("afull", afull, 1'b0);
    check_word("rd_data", rd_data, '0);
    end_test();

    start_test("ordered data");
    run_random_phase(50, 50);
    drain_all();
    settle_and_check_flags();
    end_test();

    start_test("full");
    settle_and_check_flags();
    base = writes;
    repeat (`FIFO_DEPTH + 8) write_step(1'b1, data_t'($urandom));
    write_step(1'b0, '0);
    check_count("writes accepted until full", writes - base, `FIFO_DEPTH);
    check_bit("full after filling", full, 1'b1);
    settle_and_check_flags();
    drain_all();
    check_bit("empty after draining", empty, 1'b1);
    end_test();

    start_test("empty");
    fill_to(5);
    settle_and_check_flags();
    base = reads;
    repeat (15) read_step(1'b1);
    read_step(1'b0);
    check_count("reads accepted until empty", reads - base, 5);
    check_count("words left in model", model.size(), 0);
    check_bit("empty after reading out", empty, 1'b1);
    check_word("rd_data held after empty", rd_data, last_read);
    end_test();

    start_test("settled flags");
    for (int k = 0; k <= `FIFO_DEPTH; k++) begin
      fill_to(k);
      settle_and_check_flags();
      drain_all();
    end
    end_test();

    start_test("bursts under back-pressure");
    run_random_phase(90, 20);
    settle_and_check_flags();
    run_random_phase(20, 90);
    drain_all();
    settle_and_check_flags();
    end_test();

    $display("Checks %0d, errors %0d, words written %0d, words read %0d",
             checks, errors, writes, reads);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* source/async_fifo.sv */
module async_fifo (
  input  logic            wr_clk,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            wr_en,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_en,
  output fifo_pkg::data_t rd_data,
  output logic            full,
  output logic            afull,
  output logic            empty,
  output logic            aempty
);

  import fifo_pkg::*;

  logic  wr_accept;
  logic  rd_accept;
  addr_t wr_addr;
  addr_t rd_addr;
  ptr_t  wr_ptr_gray;
  ptr_t  rd_ptr_gray;
  ptr_t  wr_ptr_gray_rd;
  ptr_t  rd_ptr_gray_wr;

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk         (wr_clk),
    .rd_rst_n       (rd_rst_n),
    .wr_en          (wr_en),
    .rd_ptr_gray_wr (rd_ptr_gray_wr),
    .wr_accept      (wr_accept),
    .wr_addr        (wr_addr),
    .wr_ptr_gray    (wr_ptr_gray),
    .full           (full),
    .afull          (afull)
  );

  fifo_mem u_mem (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  // Write pointer into the read domain.
  gray_sync wr_ptr_sync (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_ptr_gray),
    .gray_out (wr_ptr_gray_rd)
  );

  // Read pointer into the write domain.
  gray_sync rd_ptr_sync (
    .clk      (wr_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (rd_ptr_gray),
    .gray_out (rd_ptr_gray_wr)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk         (rd_clk),
    .rd_rst_n       (rd_rst_n),
    .rd_en          (rd_en),
    .wr_ptr_gray_rd (wr_ptr_gray_rd),
    .rd_accept      (rd_accept),
    .rd_addr        (rd_addr),
    .rd_ptr_gray    (rd_ptr_gray),
    .empty          (empty),
    .aempty         (aempty)
  );

endmodule

/* source/fifo_rd_ctrl.sv */
`include "fifo_defines.svh"

module fifo_rd_ctrl (
  input  logic           rd_clk,
  input  logic           rd_rst_n,
  input  logic           rd_en,
  input  fifo_pkg::ptr_t wr_ptr_gray_rd,
  output logic           rd_accept,
  output fifo_pkg::addr_t rd_addr,
  output fifo_pkg::ptr_t rd_ptr_gray,
  output logic           empty,
  output logic           aempty
);

  import fifo_pkg::*;

  logic [1:0] rst_sync;
  logic       rd_rst_sync_n;

  ptr_t rd_ptr_bin;
  ptr_t rd_ptr_next;
  ptr_t rd_ptr_gray_next;
  ptr_t wr_ptr_bin_rd;
  ptr_t fill_rd;
  logic empty_next;
  logic aempty_next;

  // Reset release synchronized to rd_clk.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rd_rst_sync_n = rst_sync[1];

  assign rd_accept        = rd_en && !empty;
  assign rd_ptr_next      = rd_ptr_bin + ptr_t'(rd_accept);
  assign rd_ptr_gray_next = bin2gray(rd_ptr_next);
  assign rd_addr          = rd_ptr_bin[FIFO_ADDR_WIDTH-1:0];

  assign wr_ptr_bin_rd = gray2bin(wr_ptr_gray_rd);
  assign fill_rd       = wr_ptr_bin_rd - rd_ptr_next;

  // Equal pointers, wrap bit included, mean nothing left.
  assign empty_next  = (rd_ptr_gray_next == wr_ptr_gray_rd);
  assign aempty_next = (fill_rd <= ptr_t'(`FIFO_AEMPTY));

  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_next;
      rd_ptr_gray <= rd_ptr_gray_next;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_next;
      aempty <= aempty_next;
    end
  end

endmodule

/* source/fifo_wr_ctrl.sv */
`include "fifo_defines.svh"

module fifo_wr_ctrl (
  input  logic           wr_clk,
  input  logic           rd_rst_n,
  input  logic           wr_en,
  input  fifo_pkg::ptr_t rd_ptr_gray_wr,
  output logic           wr_accept,
  output fifo_pkg::addr_t wr_addr,
  output fifo_pkg::ptr_t wr_ptr_gray,
  output logic           full,
  output logic           afull
);

  import fifo_pkg::*;

  // Top two Gray bits differ when the writer is one lap ahead.
  localparam ptr_t FULL_MASK = ptr_t'(2'b11) << (FIFO_ADDR_WIDTH - 1);

  logic [1:0] rst_sync;
  logic       wr_rst_n;

  ptr_t wr_ptr_bin;
  ptr_t wr_ptr_next;
  ptr_t wr_ptr_gray_next;
  ptr_t rd_ptr_bin_wr;
  ptr_t fill_wr;
  logic full_next;
  logic afull_next;

  // Reset release synchronized to wr_clk.
  always_ff @(posedge wr_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign wr_rst_n = rst_sync[1];

  assign wr_accept        = wr_en && !full;
  assign wr_ptr_next      = wr_ptr_bin + ptr_t'(wr_accept);
  assign wr_ptr_gray_next = bin2gray(wr_ptr_next);
  assign wr_addr          = wr_ptr_bin[FIFO_ADDR_WIDTH-1:0];

  assign rd_ptr_bin_wr = gray2bin(rd_ptr_gray_wr);
  assign fill_wr       = wr_ptr_next - rd_ptr_bin_wr;

  assign full_next  = (wr_ptr_gray_next == (rd_ptr_gray_wr ^ FULL_MASK));
  assign afull_next = (fill_wr >= ptr_t'(`FIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_next;
      wr_ptr_gray <= wr_ptr_gray_next;
    end
  end

  // Flags look at the next pointer so they are exact after the edge.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_next;
      afull <= afull_next;
    end
  end

endmodule

/* source/fifo_mem.sv */
`include "fifo_defines.svh"

module fifo_mem (
  input  logic            wr_clk,
  input  logic            wr_accept,
  input  fifo_pkg::addr_t wr_addr,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            rd_accept,
  input  fifo_pkg::addr_t rd_addr,
  output fifo_pkg::data_t rd_data
);

  import fifo_pkg::*;

  data_t mem [`FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Output holds the last read word between reads.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* source/gray_sync.sv */
module gray_sync (
  input  logic           clk,
  input  logic           rst_n,
  input  fifo_pkg::ptr_t gray_in,
  output fifo_pkg::ptr_t gray_out
);

  import fifo_pkg::*;

  ptr_t sync_q1;
  ptr_t sync_q2;

  // Only one bit moves per step, so each sample is a real past pointer.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  assign gray_out = sync_q2;

endmodule

/* source/fifo_pkg.sv */
`include "fifo_defines.svh"

package fifo_pkg;

  localparam int FIFO_ADDR_WIDTH = $clog2(`FIFO_DEPTH);

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [FIFO_ADDR_WIDTH-1:0]  addr_t;
  // One extra wrap bit tells full from empty.
  typedef logic [FIFO_ADDR_WIDTH:0]    ptr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[FIFO_ADDR_WIDTH] = gray[FIFO_ADDR_WIDTH];
    for (int i = FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* include/fifo_defines.svh */
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// Width of one stored word.
`define FIFO_DATA_WIDTH 8

// Number of entries, a power of two.
`define FIFO_DEPTH 16

// Fill levels for the almost flags.
`define FIFO_AFULL (`FIFO_DEPTH - 2)
`define FIFO_AEMPTY 2

`endif
